// File: common/cce_inst_pkg.sv
/*
  Microcode instruction encoding
  Field widths and bit positions, instruction and field typedefs,
  op class enum and the per-class minor op enums
*/
package cce_inst_pkg;

  localparam int inst_width = 32;
  localparam int op_width = 3;
  localparam int minor_op_width = 4;
  localparam int reg_id_width = 3;
  localparam int imm_width = 16;

  // Bit positions of the instruction fields
  localparam int op_lsb = 29;
  localparam int minor_op_lsb = 25;
  localparam int dst_lsb = 22;
  localparam int src_a_lsb = 19;
  localparam int src_b_lsb = 16;
  localparam int imm_lsb = 0;

  typedef logic [inst_width-1:0] cce_inst_t;
  typedef logic [minor_op_width-1:0] minor_op_t;
  // Names a GPR, a special register or a flag, depending on the op
  typedef logic [reg_id_width-1:0] reg_id_t;
  typedef logic [imm_width-1:0] imm_t;

  // Dir, misc and queue classes pass through without decoded controls
  typedef enum logic [op_width-1:0] {
    e_op_alu    = 3'd0,
    e_op_branch = 3'd1,
    e_op_move   = 3'd2,
    e_op_flag   = 3'd3,
    e_op_dir    = 3'd4,
    e_op_misc   = 3'd5,
    e_op_queue  = 3'd6
  } op_class_e;

  typedef enum logic [minor_op_width-1:0] {
    e_add_op = 4'd0,
    e_sub_op = 4'd1,
    e_and_op = 4'd2,
    e_or_op  = 4'd3
  } alu_minor_e;

  typedef enum logic [minor_op_width-1:0] {
    e_br_op = 4'd0,
    e_bf_op = 4'd1,
    e_bs_op = 4'd2
  } branch_minor_e;

  typedef enum logic [minor_op_width-1:0] {
    e_movi_op  = 4'd0,
    e_mov_op   = 4'd1,
    e_movf_op  = 4'd2,
    e_movsg_op = 4'd3,
    e_movgs_op = 4'd4
  } move_minor_e;

  typedef enum logic [minor_op_width-1:0] {
    e_setf_op = 4'd0,
    e_andf_op = 4'd1,
    e_orf_op  = 4'd2
  } flag_minor_e;

endpackage

// File: common/cce_ctrl_pkg.sv
/*
  Decoded control vocabulary
  Operand source and destination selectors,
  GPR and flag counts, write mask types
*/
package cce_ctrl_pkg;

  localparam int sel_width = 2;

  // Where an operand is read from
  typedef enum logic [sel_width-1:0] {
    e_src_sel_gpr     = 2'd0,
    e_src_sel_flag    = 2'd1,
    e_src_sel_special = 2'd2,
    e_src_sel_imm     = 2'd3
  } src_sel_e;

  // Which register file the result goes to
  typedef enum logic [sel_width-1:0] {
    e_dst_sel_none    = 2'd0,
    e_dst_sel_gpr     = 2'd1,
    e_dst_sel_special = 2'd2,
    e_dst_sel_flag    = 2'd3
  } dst_sel_e;

  localparam int num_gprs = 8;
  localparam int num_flags = 8;

  // One bit per register, at most one set per instruction
  typedef logic [num_gprs-1:0] gpr_mask_t;
  typedef logic [num_flags-1:0] flag_mask_t;

endpackage

// File: source/cce_inst_stage.sv
/*
  Execute stage registers
  Instruction, PC and valid bit, held on stall,
  valid cleared after a mispredict
*/
`timescale 1ns/1ps

module cce_inst_stage #(
  parameter int cce_pc_width_p = 8
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  cce_inst_pkg::cce_inst_t   inst_i,
  input  logic [cce_pc_width_p-1:0] pc_i,
  input  logic                      inst_v_i,
  input  logic                      stall_i,
  input  logic                      mispredict_i,
  output cce_inst_pkg::cce_inst_t   ex_inst_o,
  output logic [cce_pc_width_p-1:0] ex_pc_o,
  output logic                      ex_v_o
);

  import cce_inst_pkg::*;

  cce_inst_t ex_inst_r, ex_inst_n;
  logic [cce_pc_width_p-1:0] ex_pc_r, ex_pc_n;
  logic ex_v_r, ex_v_n;

  // Stall replays the current instruction, so it wins over mispredict
  always_comb begin
    ex_inst_n = stall_i ? ex_inst_r : inst_i;
    ex_pc_n = stall_i ? ex_pc_r : pc_i;
    if (stall_i) begin
      ex_v_n = ex_v_r;
    end else if (mispredict_i) begin
      // Fetch is redirected, so the instruction behind the branch is a bubble
      ex_v_n = 1'b0;
    end else begin
      ex_v_n = inst_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_inst_r <= '0;
      ex_pc_r <= '0;
      ex_v_r <= 1'b0;
    end else begin
      ex_inst_r <= ex_inst_n;
      ex_pc_r <= ex_pc_n;
      ex_v_r <= ex_v_n;
    end
  end

  assign ex_inst_o = ex_inst_r;
  assign ex_pc_o = ex_pc_r;
  assign ex_v_o = ex_v_r;

endmodule

// File: decode/cce_arith_branch_decode.sv
/*
  Raw control decode for the ALU and branch classes
  Operand selects, ALU and branch valids, branch target
*/
`timescale 1ns/1ps

module cce_arith_branch_decode #(
  parameter int cce_pc_width_p = 8
) (
  input  cce_inst_pkg::cce_inst_t   ex_inst_i,
  output logic                      alu_v_o,
  output logic                      branch_v_o,
  output logic                      alu_w_v_o,
  output cce_ctrl_pkg::src_sel_e    src_a_sel_o,
  output cce_ctrl_pkg::src_sel_e    src_b_sel_o,
  output logic [cce_pc_width_p-1:0] branch_target_o
);

  import cce_inst_pkg::*;
  import cce_ctrl_pkg::*;

  op_class_e op;
  minor_op_t minor_op;
  imm_t imm;

  assign op = op_class_e'(ex_inst_i[op_lsb +: op_width]);
  assign minor_op = ex_inst_i[minor_op_lsb +: minor_op_width];
  assign imm = ex_inst_i[imm_lsb +: imm_width];

  always_comb begin
    alu_v_o = 1'b0;
    branch_v_o = 1'b0;
    alu_w_v_o = 1'b0;
    src_a_sel_o = e_src_sel_gpr;
    src_b_sel_o = e_src_sel_gpr;
    branch_target_o = '0;

    case (op)
      e_op_alu: begin
        // Every ALU op writes its result to a GPR
        alu_v_o = 1'b1;
        alu_w_v_o = 1'b1;
      end

      e_op_branch: begin
        branch_v_o = 1'b1;
        branch_target_o = imm[cce_pc_width_p-1:0];
        case (minor_op)
          e_bf_op: begin
            // Flag compared against the value held in the immediate
            src_a_sel_o = e_src_sel_flag;
            src_b_sel_o = e_src_sel_imm;
          end
          e_bs_op: begin
            src_a_sel_o = e_src_sel_special;
            src_b_sel_o = e_src_sel_gpr;
          end
          default: begin
            // BR compares two GPRs
            src_a_sel_o = e_src_sel_gpr;
            src_b_sel_o = e_src_sel_gpr;
          end
        endcase
      end

      default: begin
      end
    endcase
  end

endmodule

// File: decode/cce_move_flag_decode.sv
/*
  Raw control decode for the move and flag classes
  Destination and source selects, move and flag write enables,
  ALU use of the ANDF and ORF flag ops
*/
`timescale 1ns/1ps

module cce_move_flag_decode (
  input  cce_inst_pkg::cce_inst_t ex_inst_i,
  output logic                    mov_w_v_o,
  output cce_ctrl_pkg::dst_sel_e  dst_sel_o,
  output cce_ctrl_pkg::src_sel_e  src_a_sel_o,
  output cce_ctrl_pkg::src_sel_e  src_b_sel_o,
  output logic                    alu_v_o,
  output cce_inst_pkg::minor_op_t alu_minor_o,
  output logic                    flag_w_v_o
);

  import cce_inst_pkg::*;
  import cce_ctrl_pkg::*;

  op_class_e op;
  minor_op_t minor_op;

  assign op = op_class_e'(ex_inst_i[op_lsb +: op_width]);
  assign minor_op = ex_inst_i[minor_op_lsb +: minor_op_width];

  always_comb begin
    mov_w_v_o = 1'b0;
    dst_sel_o = e_dst_sel_none;
    src_a_sel_o = e_src_sel_gpr;
    src_b_sel_o = e_src_sel_gpr;
    alu_v_o = 1'b0;
    alu_minor_o = '0;
    flag_w_v_o = 1'b0;

    case (op)
      e_op_move: begin
        mov_w_v_o = 1'b1;
        case (minor_op)
          e_movi_op: begin
            dst_sel_o = e_dst_sel_gpr;
            src_a_sel_o = e_src_sel_imm;
          end
          e_mov_op: begin
            dst_sel_o = e_dst_sel_gpr;
            src_a_sel_o = e_src_sel_gpr;
          end
          e_movf_op: begin
            dst_sel_o = e_dst_sel_gpr;
            src_a_sel_o = e_src_sel_flag;
          end
          e_movsg_op: begin
            dst_sel_o = e_dst_sel_gpr;
            src_a_sel_o = e_src_sel_special;
          end
          e_movgs_op: begin
            dst_sel_o = e_dst_sel_special;
            src_a_sel_o = e_src_sel_gpr;
          end
          default: begin
            // Unknown move writes nothing
            mov_w_v_o = 1'b0;
          end
        endcase
      end

      e_op_flag: begin
        case (minor_op)
          e_setf_op: begin
            // Flag value comes from the immediate
            dst_sel_o = e_dst_sel_flag;
            flag_w_v_o = 1'b1;
          end
          e_andf_op, e_orf_op: begin
            // Two flags combined by the ALU into a GPR
            dst_sel_o = e_dst_sel_gpr;
            src_a_sel_o = e_src_sel_flag;
            src_b_sel_o = e_src_sel_flag;
            alu_v_o = 1'b1;
            alu_minor_o = (minor_op == e_andf_op) ? e_and_op : e_or_op;
          end
          default: begin
          end
        endcase
      end

      default: begin
      end
    endcase
  end

endmodule

// File: decode/cce_write_enable_gen.sv
/*
  Class select, valid gating and write masks
  Picks the controls of the decoder that owns the op class,
  zeroes them for an invalid slot, forms GPR and flag write masks
*/
`timescale 1ns/1ps

module cce_write_enable_gen #(
  parameter int cce_pc_width_p = 8
) (
  input  cce_inst_pkg::cce_inst_t   ex_inst_i,
  input  logic                      ex_v_i,
  // From the ALU and branch decoder
  input  logic                      ab_alu_v_i,
  input  logic                      ab_branch_v_i,
  input  logic                      ab_alu_w_v_i,
  input  cce_ctrl_pkg::src_sel_e    ab_src_a_sel_i,
  input  cce_ctrl_pkg::src_sel_e    ab_src_b_sel_i,
  input  logic [cce_pc_width_p-1:0] ab_branch_target_i,
  // From the move and flag decoder
  input  logic                      mf_mov_w_v_i,
  input  cce_ctrl_pkg::dst_sel_e    mf_dst_sel_i,
  input  cce_ctrl_pkg::src_sel_e    mf_src_a_sel_i,
  input  cce_ctrl_pkg::src_sel_e    mf_src_b_sel_i,
  input  logic                      mf_alu_v_i,
  input  cce_inst_pkg::minor_op_t   mf_alu_minor_i,
  input  logic                      mf_flag_w_v_i,
  output logic                      decoded_v_o,
  output logic                      alu_v_o,
  output logic                      branch_v_o,
  output cce_inst_pkg::op_class_e   op_o,
  output cce_inst_pkg::minor_op_t   minor_op_o,
  output cce_ctrl_pkg::dst_sel_e    dst_sel_o,
  output cce_ctrl_pkg::src_sel_e    src_a_sel_o,
  output cce_ctrl_pkg::src_sel_e    src_b_sel_o,
  output cce_inst_pkg::reg_id_t     dst_o,
  output cce_inst_pkg::reg_id_t     src_a_o,
  output cce_inst_pkg::reg_id_t     src_b_o,
  output cce_inst_pkg::imm_t        imm_o,
  output logic [cce_pc_width_p-1:0] branch_target_o,
  output cce_ctrl_pkg::gpr_mask_t   gpr_w_mask_o,
  output cce_ctrl_pkg::flag_mask_t  flag_w_mask_o
);

  import cce_inst_pkg::*;
  import cce_ctrl_pkg::*;

  op_class_e op;
  minor_op_t minor_op;
  reg_id_t dst;

  logic alu_v;
  logic branch_v;
  dst_sel_e dst_sel;
  src_sel_e src_a_sel;
  src_sel_e src_b_sel;
  logic [cce_pc_width_p-1:0] branch_target;
  logic gpr_w;
  logic flag_w;

  assign op = op_class_e'(ex_inst_i[op_lsb +: op_width]);
  assign minor_op = ex_inst_i[minor_op_lsb +: minor_op_width];
  assign dst = ex_inst_i[dst_lsb +: reg_id_width];

  always_comb begin
    alu_v = 1'b0;
    branch_v = 1'b0;
    dst_sel = e_dst_sel_none;
    src_a_sel = e_src_sel_gpr;
    src_b_sel = e_src_sel_gpr;
    branch_target = '0;
    gpr_w = 1'b0;
    flag_w = 1'b0;

    case (op)
      e_op_alu: begin
        alu_v = ab_alu_v_i;
        dst_sel = e_dst_sel_gpr;
        src_a_sel = ab_src_a_sel_i;
        src_b_sel = ab_src_b_sel_i;
        gpr_w = ab_alu_w_v_i;
      end
      e_op_branch: begin
        branch_v = ab_branch_v_i;
        src_a_sel = ab_src_a_sel_i;
        src_b_sel = ab_src_b_sel_i;
        branch_target = ab_branch_target_i;
      end
      e_op_move: begin
        dst_sel = mf_dst_sel_i;
        src_a_sel = mf_src_a_sel_i;
        src_b_sel = mf_src_b_sel_i;
        // MOVGS targets a special register, not the GPR file
        gpr_w = mf_mov_w_v_i && (mf_dst_sel_i == e_dst_sel_gpr);
      end
      e_op_flag: begin
        dst_sel = mf_dst_sel_i;
        src_a_sel = mf_src_a_sel_i;
        src_b_sel = mf_src_b_sel_i;
        alu_v = mf_alu_v_i;
        gpr_w = mf_alu_v_i && (mf_dst_sel_i == e_dst_sel_gpr);
        flag_w = mf_flag_w_v_i;
      end
      default: begin
      end
    endcase
  end

  // Fields pass through whether the slot is valid or not
  assign decoded_v_o = ex_v_i;
  assign op_o = op;
  // ANDF and ORF present the ALU opcode they run on
  assign minor_op_o = (op == e_op_flag && mf_alu_v_i) ? mf_alu_minor_i : minor_op;
  assign dst_o = dst;
  assign src_a_o = ex_inst_i[src_a_lsb +: reg_id_width];
  assign src_b_o = ex_inst_i[src_b_lsb +: reg_id_width];
  assign imm_o = ex_inst_i[imm_lsb +: imm_width];

  // An invalid slot must not act on any unit
  assign alu_v_o = ex_v_i && alu_v;
  assign branch_v_o = ex_v_i && branch_v;
  assign dst_sel_o = ex_v_i ? dst_sel : e_dst_sel_none;
  assign src_a_sel_o = ex_v_i ? src_a_sel : e_src_sel_gpr;
  assign src_b_sel_o = ex_v_i ? src_b_sel : e_src_sel_gpr;
  assign branch_target_o = ex_v_i ? branch_target : '0;

  assign gpr_w_mask_o = (ex_v_i && gpr_w) ? (gpr_mask_t'(1'b1) << dst) : '0;
  assign flag_w_mask_o = (ex_v_i && flag_w) ? (flag_mask_t'(1'b1) << dst) : '0;

endmodule

// File: source/cce_inst_decode.sv
/*
  Decode and execute stage front end of the CCE microcode engine
  Stage register, the two class decoders and the write enable stage
*/
`timescale 1ns/1ps

module cce_inst_decode #(
  parameter int cce_pc_width_p = 8
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // From the instruction RAM
  input  cce_inst_pkg::cce_inst_t   inst_i,
  input  logic [cce_pc_width_p-1:0] pc_i,
  input  logic                      inst_v_i,
  input  logic                      stall_i,
  input  logic                      mispredict_i,
  output logic [cce_pc_width_p-1:0] pc_o,
  output logic                      decoded_v_o,
  output logic                      alu_v_o,
  output logic                      branch_v_o,
  output cce_inst_pkg::op_class_e   op_o,
  output cce_inst_pkg::minor_op_t   minor_op_o,
  output cce_ctrl_pkg::dst_sel_e    dst_sel_o,
  output cce_ctrl_pkg::src_sel_e    src_a_sel_o,
  output cce_ctrl_pkg::src_sel_e    src_b_sel_o,
  output cce_inst_pkg::reg_id_t     dst_o,
  output cce_inst_pkg::reg_id_t     src_a_o,
  output cce_inst_pkg::reg_id_t     src_b_o,
  output cce_inst_pkg::imm_t        imm_o,
  output logic [cce_pc_width_p-1:0] branch_target_o,
  output cce_ctrl_pkg::gpr_mask_t   gpr_w_mask_o,
  output cce_ctrl_pkg::flag_mask_t  flag_w_mask_o
);

  import cce_inst_pkg::*;
  import cce_ctrl_pkg::*;

  cce_inst_t ex_inst;
  logic ex_v;

  logic ab_alu_v;
  logic ab_branch_v;
  logic ab_alu_w_v;
  src_sel_e ab_src_a_sel;
  src_sel_e ab_src_b_sel;
  logic [cce_pc_width_p-1:0] ab_branch_target;

  logic mf_mov_w_v;
  dst_sel_e mf_dst_sel;
  src_sel_e mf_src_a_sel;
  src_sel_e mf_src_b_sel;
  logic mf_alu_v;
  minor_op_t mf_alu_minor;
  logic mf_flag_w_v;

  // PC of the execute stage leaves the block directly
  cce_inst_stage #(
    .cce_pc_width_p(cce_pc_width_p)
  ) i_cce_inst_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_v_i     (inst_v_i),
    .stall_i      (stall_i),
    .mispredict_i (mispredict_i),
    .ex_inst_o    (ex_inst),
    .ex_pc_o      (pc_o),
    .ex_v_o       (ex_v)
  );

  cce_arith_branch_decode #(
    .cce_pc_width_p(cce_pc_width_p)
  ) i_cce_arith_branch_decode (
    .ex_inst_i       (ex_inst),
    .alu_v_o         (ab_alu_v),
    .branch_v_o      (ab_branch_v),
    .alu_w_v_o       (ab_alu_w_v),
    .src_a_sel_o     (ab_src_a_sel),
    .src_b_sel_o     (ab_src_b_sel),
    .branch_target_o (ab_branch_target)
  );

  cce_move_flag_decode i_cce_move_flag_decode (
    .ex_inst_i   (ex_inst),
    .mov_w_v_o   (mf_mov_w_v),
    .dst_sel_o   (mf_dst_sel),
    .src_a_sel_o (mf_src_a_sel),
    .src_b_sel_o (mf_src_b_sel),
    .alu_v_o     (mf_alu_v),
    .alu_minor_o (mf_alu_minor),
    .flag_w_v_o  (mf_flag_w_v)
  );

  cce_write_enable_gen #(
    .cce_pc_width_p(cce_pc_width_p)
  ) i_cce_write_enable_gen (
    .ex_inst_i          (ex_inst),
    .ex_v_i             (ex_v),
    .ab_alu_v_i         (ab_alu_v),
    .ab_branch_v_i      (ab_branch_v),
    .ab_alu_w_v_i       (ab_alu_w_v),
    .ab_src_a_sel_i     (ab_src_a_sel),
    .ab_src_b_sel_i     (ab_src_b_sel),
    .ab_branch_target_i (ab_branch_target),
    .mf_mov_w_v_i       (mf_mov_w_v),
    .mf_dst_sel_i       (mf_dst_sel),
    .mf_src_a_sel_i     (mf_src_a_sel),
    .mf_src_b_sel_i     (mf_src_b_sel),
    .mf_alu_v_i         (mf_alu_v),
    .mf_alu_minor_i     (mf_alu_minor),
    .mf_flag_w_v_i      (mf_flag_w_v),
    .decoded_v_o        (decoded_v_o),
    .alu_v_o            (alu_v_o),
    .branch_v_o         (branch_v_o),
    .op_o               (op_o),
    .minor_op_o         (minor_op_o),
    .dst_sel_o          (dst_sel_o),
    .src_a_sel_o        (src_a_sel_o),
    .src_b_sel_o        (src_b_sel_o),
    .dst_o              (dst_o),
    .src_a_o            (src_a_o),
    .src_b_o            (src_b_o),
    .imm_o              (imm_o),
    .branch_target_o    (branch_target_o),
    .gpr_w_mask_o       (gpr_w_mask_o),
    .flag_w_mask_o      (flag_w_mask_o)
  );

endmodule

// File: tests/cce_inst_decode_checker.sv
/*
  Bound timing checks for the decode front end
  Reset values, hold under stall, mispredict bubble
  and the shape of the GPR and flag write masks
*/
`timescale 1ns/1ps

module cce_inst_decode_checker #(
  parameter int cce_pc_width_p = 8,
  parameter int ctrl_width_p = 40 + cce_pc_width_p
) (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      stall_i,
  input logic                      mispredict_i,
  input logic [cce_pc_width_p-1:0] pc_i,
  input logic                      decoded_v_i,
  // ALU and branch valids on top, then the decoded fields
  input logic [ctrl_width_p-1:0]   ctrl_i,
  input cce_ctrl_pkg::gpr_mask_t   gpr_w_mask_i,
  input cce_ctrl_pkg::flag_mask_t  flag_w_mask_i
);

  int unsigned error_count = 0;

  // The edge after reset shows an empty slot at PC zero
  reset_clear_a: assert property (@(posedge clk_i)
    reset_i |=> (!decoded_v_i && pc_i == '0 && ctrl_i[ctrl_width_p-1 -: 2] == 2'b00
                 && gpr_w_mask_i == '0 && flag_w_mask_i == '0))
    else begin
      error_count = error_count + 1;
      $error("Outputs not cleared one cycle after reset");
    end

  invalid_no_write_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !decoded_v_i |-> (gpr_w_mask_i == '0 && flag_w_mask_i == '0))
    else begin
      error_count = error_count + 1;
      $error("Write mask set for an invalid slot");
    end

  // A stalled stage keeps every output for the next cycle
  stall_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i |=> $stable({pc_i, decoded_v_i, ctrl_i, gpr_w_mask_i, flag_w_mask_i}))
    else begin
      error_count = error_count + 1;
      $error("Outputs changed across a stall");
    end

  mispredict_bubble_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (mispredict_i && !stall_i) |=> !decoded_v_i)
    else begin
      error_count = error_count + 1;
      $error("Instruction after a mispredict is still valid");
    end

  // An instruction writes at most one GPR or one flag
  mask_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({gpr_w_mask_i, flag_w_mask_i}))
    else begin
      error_count = error_count + 1;
      $error("More than one register set across the write masks");
    end

endmodule

bind cce_inst_decode cce_inst_decode_checker #(
  .cce_pc_width_p(cce_pc_width_p)
) i_cce_inst_decode_checker (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .stall_i       (stall_i),
  .mispredict_i  (mispredict_i),
  .pc_i          (pc_o),
  .decoded_v_i   (decoded_v_o),
  .ctrl_i        ({alu_v_o, branch_v_o, op_o, minor_op_o, dst_sel_o, src_a_sel_o,
                   src_b_sel_o, dst_o, src_a_o, src_b_o, imm_o, branch_target_o}),
  .gpr_w_mask_i  (gpr_w_mask_o),
  .flag_w_mask_i (flag_w_mask_o)
);

// File: tests/tb_cce_inst_decode.sv
/*
  Testbench for the decode front end
  Random stimulus, reference model of the stage and decode rules,
  output comparison on the falling edge and a watchdog
*/
`timescale 1ns/1ps

module tb_cce_inst_decode;

  localparam int pc_width = 8;
  localparam int num_cycles = 2000;
  // Reset, stimulus and some slack, at 10 ns per cycle
  localparam int watchdog_ns = (num_cycles + 4 + 10) * 10 + 200;

  logic clk_i;
  logic reset_i;
  logic [31:0] inst_i;
  logic [pc_width-1:0] pc_i;
  logic inst_v_i;
  logic stall_i;
  logic mispredict_i;

  logic [pc_width-1:0] pc_o;
  logic decoded_v_o;
  logic alu_v_o;
  logic branch_v_o;
  logic [2:0] op_o;
  logic [3:0] minor_op_o;
  logic [1:0] dst_sel_o;
  logic [1:0] src_a_sel_o;
  logic [1:0] src_b_sel_o;
  logic [2:0] dst_o;
  logic [2:0] src_a_o;
  logic [2:0] src_b_o;
  logic [15:0] imm_o;
  logic [pc_width-1:0] branch_target_o;
  logic [7:0] gpr_w_mask_o;
  logic [7:0] flag_w_mask_o;

  // Reference copy of the execute stage
  logic [31:0] model_inst;
  logic [pc_width-1:0] model_pc;
  logic model_v;
  logic [31:0] rng_state;

  cce_inst_decode #(
    .cce_pc_width_p(pc_width)
  ) i_cce_inst_decode (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .inst_v_i        (inst_v_i),
    .stall_i         (stall_i),
    .mispredict_i    (mispredict_i),
    .pc_o            (pc_o),
    .decoded_v_o     (decoded_v_o),
    .alu_v_o         (alu_v_o),
    .branch_v_o      (branch_v_o),
    .op_o            (op_o),
    .minor_op_o      (minor_op_o),
    .dst_sel_o       (dst_sel_o),
    .src_a_sel_o     (src_a_sel_o),
    .src_b_sel_o     (src_b_sel_o),
    .dst_o           (dst_o),
    .src_a_o         (src_a_o),
    .src_b_o         (src_b_o),
    .imm_o           (imm_o),
    .branch_target_o (branch_target_o),
    .gpr_w_mask_o    (gpr_w_mask_o),
    .flag_w_mask_o   (flag_w_mask_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Stall holds, mispredict leaves a bubble
  always @(posedge clk_i) begin
    if (reset_i) begin
      model_inst <= '0;
      model_pc <= '0;
      model_v <= 1'b0;
    end else if (!stall_i) begin
      model_inst <= inst_i;
      model_pc <= pc_i;
      model_v <= inst_v_i && !mispredict_i;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("Error at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
        abort_run("Output mismatch against the reference model");
      end
  endtask

  task automatic check_outputs();
    logic [2:0] op;
    logic [3:0] minor;
    logic [2:0] dst;
    logic [3:0] exp_minor;
    logic exp_alu_v;
    logic exp_branch_v;
    logic [1:0] exp_dst_sel;
    logic [1:0] exp_src_a_sel;
    logic [1:0] exp_src_b_sel;
    logic [pc_width-1:0] exp_target;
    logic [7:0] exp_gpr_mask;
    logic [7:0] exp_flag_mask;
    op = model_inst[31:29];
    minor = model_inst[28:25];
    dst = model_inst[24:22];
    exp_minor = minor;
    exp_alu_v = 1'b0;
    exp_branch_v = 1'b0;
    exp_dst_sel = 2'd0;
    exp_src_a_sel = 2'd0;
    exp_src_b_sel = 2'd0;
    exp_target = '0;
    exp_gpr_mask = '0;
    exp_flag_mask = '0;
    case (op)
      3'd0: begin
        exp_alu_v = 1'b1;
        exp_dst_sel = 2'd1;
        exp_gpr_mask = 8'd1 << dst;
      end
      3'd1: begin
        exp_branch_v = 1'b1;
        exp_target = model_inst[pc_width-1:0];
        if (minor == 4'd1) begin
          exp_src_a_sel = 2'd1;
          exp_src_b_sel = 2'd3;
        end else if (minor == 4'd2) begin
          exp_src_a_sel = 2'd2;
        end
      end
      3'd2: begin
        // MOVI, MOV, MOVF, MOVSG write a GPR; MOVGS writes a special register
        case (minor)
          4'd0: exp_src_a_sel = 2'd3;
          4'd2: exp_src_a_sel = 2'd1;
          4'd3: exp_src_a_sel = 2'd2;
          default: ;
        endcase
        if (minor <= 4'd3) begin
          exp_dst_sel = 2'd1;
          exp_gpr_mask = 8'd1 << dst;
        end else if (minor == 4'd4) begin
          exp_dst_sel = 2'd2;
        end
      end
      3'd3: begin
        if (minor == 4'd0) begin
          exp_dst_sel = 2'd3;
          exp_flag_mask = 8'd1 << dst;
        end else if (minor == 4'd1 || minor == 4'd2) begin
          exp_alu_v = 1'b1;
          exp_dst_sel = 2'd1;
          exp_src_a_sel = 2'd1;
          exp_src_b_sel = 2'd1;
          exp_gpr_mask = 8'd1 << dst;
          // ANDF shows the ALU and code, ORF the ALU or code
          exp_minor = minor + 4'd1;
        end
      end
      default: ;
    endcase
    if (!model_v) begin
      exp_alu_v = 1'b0;
      exp_branch_v = 1'b0;
      exp_dst_sel = 2'd0;
      exp_src_a_sel = 2'd0;
      exp_src_b_sel = 2'd0;
      exp_target = '0;
      exp_gpr_mask = '0;
      exp_flag_mask = '0;
    end
    check_value("pc_o", model_pc, pc_o);
    check_value("decoded_v_o", model_v, decoded_v_o);
    check_value("op_o", op, op_o);
    check_value("minor_op_o", exp_minor, minor_op_o);
    check_value("dst_o", dst, dst_o);
    check_value("src_a_o", model_inst[21:19], src_a_o);
    check_value("src_b_o", model_inst[18:16], src_b_o);
    check_value("imm_o", model_inst[15:0], imm_o);
    check_value("alu_v_o", exp_alu_v, alu_v_o);
    check_value("branch_v_o", exp_branch_v, branch_v_o);
    check_value("dst_sel_o", exp_dst_sel, dst_sel_o);
    check_value("src_a_sel_o", exp_src_a_sel, src_a_sel_o);
    check_value("src_b_sel_o", exp_src_b_sel, src_b_sel_o);
    check_value("branch_target_o", exp_target, branch_target_o);
    check_value("gpr_w_mask_o", exp_gpr_mask, gpr_w_mask_o);
    check_value("flag_w_mask_o", exp_flag_mask, flag_w_mask_o);
  endtask

  task automatic check_bound_assertions();
    if (i_cce_inst_decode.i_cce_inst_decode_checker.error_count != 0) begin
      abort_run("A bound timing assertion on the DUT failed");
    end
  endtask

  // Mostly kept classes, with some dropped ones and unknown minor ops
  task automatic drive_random_inputs();
    logic [31:0] r;
    logic [31:0] fields;
    logic [2:0] op;
    logic [3:0] minor;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    rng_state = xorshift32(rng_state);
    fields = rng_state;
    op = (r[3:0] < 4'd13) ? {1'b0, r[5:4]} : 3'd4 + {1'b0, r[5:4]};
    minor = (r[13] && r[14]) ? r[12:9] : {1'b0, r[8:6]};
    inst_i = {op, minor, fields[24:0]};
    pc_i = r[31:24];
    inst_v_i = (r[17:15] != 3'd0);
    stall_i = (r[20:18] < 3'd2);
    mispredict_i = (r[23:21] == 3'd0);
  endtask

  initial begin
    rng_state = 32'd76;
    reset_i = 1'b1;
    inst_i = '0;
    pc_i = '0;
    inst_v_i = 1'b0;
    stall_i = 1'b0;
    mispredict_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    drive_random_inputs();
    for (int i = 0; i < num_cycles; i++) begin
      @(negedge clk_i);
      check_outputs();
      check_bound_assertions();
      drive_random_inputs();
    end
    if (i_cce_inst_decode.i_cce_inst_decode_checker.error_count != 0) begin
      abort_run("A bound timing assertion on the DUT failed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  initial begin
    #(watchdog_ns);
    abort_run("Watchdog expired before the stimulus finished");
  end

endmodule

// File: cce_inst_decode.f
common/cce_inst_pkg.sv
common/cce_ctrl_pkg.sv
source/cce_inst_stage.sv
decode/cce_arith_branch_decode.sv
decode/cce_move_flag_decode.sv
decode/cce_write_enable_gen.sv
source/cce_inst_decode.sv
tests/cce_inst_decode_checker.sv
tests/tb_cce_inst_decode.sv

// File: Bender.yml
package:
  name: cce_inst_decode

sources:
  - common/cce_inst_pkg.sv
  - common/cce_ctrl_pkg.sv
  - source/cce_inst_stage.sv
  - decode/cce_arith_branch_decode.sv
  - decode/cce_move_flag_decode.sv
  - decode/cce_write_enable_gen.sv
  - source/cce_inst_decode.sv
  - target: test
    files:
      - tests/cce_inst_decode_checker.sv
      - tests/tb_cce_inst_decode.sv
